//--- common/bf16_pkg.sv
// BF16 adder definitions

`default_nettype none

package bf16_pkg;

        // ======================================================================
        // Field widths
        // ======================================================================
        localparam int EXP_W      = 8;
        localparam int MANT_W     = 7;
        localparam int GRS_W      = 3;
        localparam int EXT_MANT_W = 1 + MANT_W + GRS_W;

        // ======================================================================
        // Types
        // ======================================================================
        typedef logic [EXP_W+MANT_W:0]  bf16_t;
        typedef logic [EXP_W-1:0]       exp_t;
        typedef logic [MANT_W-1:0]      mant_t;
        // Implied one, mantissa, guard, round, sticky
        typedef logic [EXT_MANT_W-1:0]  ext_mant_t;
        // Extended significand plus a carry bit
        typedef logic [EXT_MANT_W:0]    sum_mant_t;
        typedef logic [3:0]             shift_t;

        // ======================================================================
        // Fixed encodings
        // ======================================================================
        localparam exp_t  EXP_ALL_ONES = 8'hFF;
        localparam bf16_t QNAN         = 16'h7FC0;

        // Clock edges from input sample to registered output
        localparam int LATENCY = 3;

endpackage : bf16_pkg

`default_nettype wire

//--- bf16_add/bf16_special_path.sv
// BF16 special case path

`default_nettype none

module bf16_special_path (
        input  wire logic            i_clk,
        input  wire logic            i_rst_n,
        input  wire bf16_pkg::bf16_t i_a,
        input  wire bf16_pkg::bf16_t i_b,
        output logic                 o_special,
        output bf16_pkg::bf16_t      o_special_result,
        output logic                 o_invalid
);

        logic            sign_a, sign_b;
        bf16_pkg::exp_t  exp_a, exp_b;
        bf16_pkg::mant_t mant_a, mant_b;
        logic            a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
        logic            inf_minus_inf;
        logic            spec_c, inv_c;
        bf16_pkg::bf16_t res_c;
        logic            spec_q, inv_q;
        bf16_pkg::bf16_t res_q;

        assign sign_a = i_a[bf16_pkg::EXP_W+bf16_pkg::MANT_W];
        assign sign_b = i_b[bf16_pkg::EXP_W+bf16_pkg::MANT_W];
        assign exp_a  = i_a[bf16_pkg::MANT_W +: bf16_pkg::EXP_W];
        assign exp_b  = i_b[bf16_pkg::MANT_W +: bf16_pkg::EXP_W];
        assign mant_a = i_a[bf16_pkg::MANT_W-1:0];
        assign mant_b = i_b[bf16_pkg::MANT_W-1:0];

        // Zero exponent covers true zero and flushed subnormals
        assign a_zero = (exp_a == '0);
        assign b_zero = (exp_b == '0);
        assign a_inf  = (exp_a == bf16_pkg::EXP_ALL_ONES) && (mant_a == '0);
        assign b_inf  = (exp_b == bf16_pkg::EXP_ALL_ONES) && (mant_b == '0);
        assign a_nan  = (exp_a == bf16_pkg::EXP_ALL_ONES) && (mant_a != '0);
        assign b_nan  = (exp_b == bf16_pkg::EXP_ALL_ONES) && (mant_b != '0);

        assign inf_minus_inf = a_inf && b_inf && (sign_a != sign_b);

        // Highest priority first
        always_comb begin
                spec_c = 1'b1;
                inv_c  = 1'b0;
                res_c  = bf16_pkg::QNAN;
                if (a_nan || b_nan || inf_minus_inf) begin
                        inv_c = inf_minus_inf;
                end else if (a_inf) begin
                        res_c = i_a;
                end else if (b_inf) begin
                        res_c = i_b;
                end else if (a_zero && b_zero) begin
                        res_c = {sign_a & sign_b, {(bf16_pkg::EXP_W+bf16_pkg::MANT_W){1'b0}}};
                end else if (a_zero) begin
                        res_c = i_b;
                end else if (b_zero) begin
                        res_c = i_a;
                end else begin
                        spec_c = 1'b0;
                end
        end

        // ======================================================================
        // Two register stages to meet the stage-2 data
        // ======================================================================
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        spec_q    <= 1'b0;
                        inv_q     <= 1'b0;
                        o_special <= 1'b0;
                        o_invalid <= 1'b0;
                end else begin
                        spec_q    <= spec_c;
                        inv_q     <= inv_c;
                        o_special <= spec_q;
                        o_invalid <= inv_q;
                end
        end

        always_ff @(posedge i_clk) begin
                res_q            <= res_c;
                o_special_result <= res_q;
        end

endmodule : bf16_special_path

`default_nettype wire

//--- bf16_add/bf16_operand_align.sv
// BF16 operand swap and alignment

`default_nettype none

module bf16_operand_align (
        input  wire logic                i_clk,
        input  wire logic                i_rst_n,
        input  wire bf16_pkg::bf16_t     i_a,
        input  wire bf16_pkg::bf16_t     i_b,
        input  wire logic                i_valid,
        output logic                     o_valid,
        output logic                     o_sign,
        output logic                     o_eff_sub,
        output bf16_pkg::exp_t           o_exp_l,
        output bf16_pkg::ext_mant_t      o_mant_l,
        output bf16_pkg::ext_mant_t      o_mant_s,
        output logic                     o_sticky
);

        localparam int MAG_W = bf16_pkg::EXP_W + bf16_pkg::MANT_W;

        logic                a_larger;
        bf16_pkg::bf16_t     op_l, op_s;
        bf16_pkg::exp_t      exp_l, exp_s, exp_diff;
        bf16_pkg::ext_mant_t ext_l, ext_s, aligned_s, shift_mask;
        bf16_pkg::shift_t    shift_amt;
        logic                sticky;

        // Exponent sits above the mantissa, so one compare orders by magnitude
        assign a_larger = (i_a[MAG_W-1:0] >= i_b[MAG_W-1:0]);
        assign op_l     = a_larger ? i_a : i_b;
        assign op_s     = a_larger ? i_b : i_a;

        assign exp_l    = op_l[bf16_pkg::MANT_W +: bf16_pkg::EXP_W];
        assign exp_s    = op_s[bf16_pkg::MANT_W +: bf16_pkg::EXP_W];
        assign exp_diff = exp_l - exp_s;

        // Implied one is always set since special operands get replaced later
        assign ext_l = {1'b1, op_l[bf16_pkg::MANT_W-1:0], {bf16_pkg::GRS_W{1'b0}}};
        assign ext_s = {1'b1, op_s[bf16_pkg::MANT_W-1:0], {bf16_pkg::GRS_W{1'b0}}};

        // Clamp so a long shift empties the significand into sticky
        assign shift_amt = (exp_diff >= bf16_pkg::EXT_MANT_W) ?
                           bf16_pkg::shift_t'(bf16_pkg::EXT_MANT_W) :
                           bf16_pkg::shift_t'(exp_diff);

        assign aligned_s  = ext_s >> shift_amt;
        // Mask of the bits that fall off the bottom
        assign shift_mask = (bf16_pkg::ext_mant_t'(1) << shift_amt) - bf16_pkg::ext_mant_t'(1);
        assign sticky     = |(ext_s & shift_mask);

        // ======================================================================
        // Stage 1 registers
        // ======================================================================
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                o_sign    <= op_l[MAG_W];
                o_eff_sub <= op_l[MAG_W] ^ op_s[MAG_W];
                o_exp_l   <= exp_l;
                o_mant_l  <= ext_l;
                o_mant_s  <= aligned_s;
                o_sticky  <= sticky;
        end

endmodule : bf16_operand_align

`default_nettype wire

//--- bf16_add/bf16_mant_addsub.sv
// BF16 significand add and subtract

`default_nettype none

module bf16_mant_addsub (
        input  wire logic                i_clk,
        input  wire logic                i_rst_n,
        input  wire logic                i_valid,
        input  wire logic                i_sign,
        input  wire logic                i_eff_sub,
        input  wire bf16_pkg::exp_t      i_exp_l,
        input  wire bf16_pkg::ext_mant_t i_mant_l,
        input  wire bf16_pkg::ext_mant_t i_mant_s,
        input  wire logic                i_sticky,
        output logic                     o_valid,
        output logic                     o_sign,
        output bf16_pkg::exp_t           o_exp_l,
        output bf16_pkg::sum_mant_t      o_sum,
        output logic                     o_sticky,
        output logic                     o_sum_zero
);

        bf16_pkg::sum_mant_t sum;

        // L holds the larger magnitude, so the difference never goes negative
        assign sum = i_eff_sub ? ({1'b0, i_mant_l} - {1'b0, i_mant_s}) :
                                 ({1'b0, i_mant_l} + {1'b0, i_mant_s});

        // ======================================================================
        // Stage 2 registers
        // ======================================================================
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                o_sign     <= i_sign;
                o_exp_l    <= i_exp_l;
                o_sum      <= sum;
                o_sticky   <= i_sticky;
                o_sum_zero <= (sum == '0) && !i_sticky;
        end

endmodule : bf16_mant_addsub

`default_nettype wire

//--- bf16_add/bf16_normalize_round.sv
// BF16 normalize, round and result select

`default_nettype none

module bf16_normalize_round (
        input  wire logic                i_clk,
        input  wire logic                i_rst_n,
        input  wire logic                i_valid,
        input  wire logic                i_sign,
        input  wire bf16_pkg::exp_t      i_exp_l,
        input  wire bf16_pkg::sum_mant_t i_sum,
        input  wire logic                i_sticky,
        input  wire logic                i_sum_zero,
        input  wire logic                i_special,
        input  wire bf16_pkg::bf16_t     i_special_result,
        input  wire logic                i_invalid,
        output logic                     o_valid,
        output bf16_pkg::bf16_t          o_result,
        output logic                     o_overflow,
        output logic                     o_underflow,
        output logic                     o_invalid
);

        localparam int MAG_W = bf16_pkg::EXP_W + bf16_pkg::MANT_W;

        bf16_pkg::shift_t    lzc, norm_shift;
        bf16_pkg::ext_mant_t mant_norm;
        logic                norm_sticky;
        logic signed [9:0]   exp_adj, exp_rnd;
        logic                guard, round_bit, sticky_bit, round_up;
        logic [bf16_pkg::MANT_W:0] mant_rnd;
        logic                rnd_carry;
        bf16_pkg::mant_t     mant_out;
        bf16_pkg::bf16_t     res_c;
        logic                ovf_c, unf_c;

        // ======================================================================
        // Leading-zero count over the 12-bit sum
        // ======================================================================
        always_comb begin
                lzc = bf16_pkg::shift_t'(bf16_pkg::EXT_MANT_W + 1);
                // Scan upward so the highest set bit wins
                for (int i = 0; i <= bf16_pkg::EXT_MANT_W; i++) begin
                        if (i_sum[i]) begin
                                lzc = bf16_pkg::shift_t'(bf16_pkg::EXT_MANT_W - i);
                        end
                end
        end

        // ======================================================================
        // Normalization
        // ======================================================================
        always_comb begin
                norm_shift = '0;
                if (i_sum[bf16_pkg::EXT_MANT_W]) begin
                        // Carry out drops one bit into sticky
                        mant_norm   = i_sum[bf16_pkg::EXT_MANT_W:1];
                        norm_sticky = i_sum[0] | i_sticky;
                        exp_adj     = $signed({2'b00, i_exp_l}) + 10'sd1;
                end else begin
                        norm_shift  = lzc - 4'd1;
                        mant_norm   = i_sum[bf16_pkg::EXT_MANT_W-1:0] << norm_shift;
                        norm_sticky = i_sticky;
                        exp_adj     = $signed({2'b00, i_exp_l}) - $signed({6'b0, norm_shift});
                end
        end

        // ======================================================================
        // Round to nearest even
        // ======================================================================
        assign guard      = mant_norm[2];
        assign round_bit  = mant_norm[1];
        assign sticky_bit = mant_norm[0] | norm_sticky;
        assign round_up   = guard && (round_bit || sticky_bit || mant_norm[3]);

        assign mant_rnd  = {1'b0, mant_norm[bf16_pkg::GRS_W +: bf16_pkg::MANT_W]} + round_up;
        assign rnd_carry = mant_rnd[bf16_pkg::MANT_W];
        // A mantissa carry leaves 1.0 at the next exponent
        assign mant_out  = rnd_carry ? '0 : mant_rnd[bf16_pkg::MANT_W-1:0];
        assign exp_rnd   = exp_adj + $signed({9'b0, rnd_carry});

        // Result priority
        always_comb begin
                res_c = {i_sign, exp_rnd[bf16_pkg::EXP_W-1:0], mant_out};
                ovf_c = 1'b0;
                unf_c = 1'b0;
                if (i_special) begin
                        res_c = i_special_result;
                end else if (i_sum_zero) begin
                        res_c = '0;
                end else if (exp_rnd >= 10'sd255) begin
                        res_c = {i_sign, bf16_pkg::EXP_ALL_ONES, {bf16_pkg::MANT_W{1'b0}}};
                        ovf_c = 1'b1;
                end else if (exp_rnd <= 10'sd0) begin
                        // Flush to a signed zero
                        res_c = {i_sign, {MAG_W{1'b0}}};
                        unf_c = 1'b1;
                end
        end

        // ======================================================================
        // Output registers
        // ======================================================================
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_valid     <= 1'b0;
                        o_result    <= '0;
                        o_overflow  <= 1'b0;
                        o_underflow <= 1'b0;
                        o_invalid   <= 1'b0;
                end else begin
                        o_valid     <= i_valid;
                        o_overflow  <= i_valid && ovf_c;
                        o_underflow <= i_valid && unf_c;
                        o_invalid   <= i_valid && i_special && i_invalid;
                        // Result holds between valid items
                        if (i_valid) begin
                                o_result <= res_c;
                        end
                end
        end

endmodule : bf16_normalize_round

`default_nettype wire

//--- verilog/bf16_adder.sv
// Pipelined BF16 adder

`default_nettype none

module bf16_adder (
        input  wire logic            i_clk,
        input  wire logic            i_rst_n,
        input  wire bf16_pkg::bf16_t i_a,
        input  wire bf16_pkg::bf16_t i_b,
        input  wire logic            i_valid,
        output bf16_pkg::bf16_t      o_result,
        output logic                 o_overflow,
        output logic                 o_underflow,
        output logic                 o_invalid,
        output logic                 o_valid
);

        // Stage 1
        logic                s1_valid, s1_sign, s1_eff_sub, s1_sticky;
        bf16_pkg::exp_t      s1_exp_l;
        bf16_pkg::ext_mant_t s1_mant_l, s1_mant_s;

        // Stage 2
        logic                s2_valid, s2_sign, s2_sticky, s2_sum_zero;
        bf16_pkg::exp_t      s2_exp_l;
        bf16_pkg::sum_mant_t s2_sum;

        // Special side path with two register stages
        logic                sp_special, sp_invalid;
        bf16_pkg::bf16_t     sp_result;

        bf16_special_path u_special (
                .i_clk            (i_clk),
                .i_rst_n          (i_rst_n),
                .i_a              (i_a),
                .i_b              (i_b),
                .o_special        (sp_special),
                .o_special_result (sp_result),
                .o_invalid        (sp_invalid)
        );

        bf16_operand_align u_align (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_a       (i_a),
                .i_b       (i_b),
                .i_valid   (i_valid),
                .o_valid   (s1_valid),
                .o_sign    (s1_sign),
                .o_eff_sub (s1_eff_sub),
                .o_exp_l   (s1_exp_l),
                .o_mant_l  (s1_mant_l),
                .o_mant_s  (s1_mant_s),
                .o_sticky  (s1_sticky)
        );

        bf16_mant_addsub u_addsub (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_valid    (s1_valid),
                .i_sign     (s1_sign),
                .i_eff_sub  (s1_eff_sub),
                .i_exp_l    (s1_exp_l),
                .i_mant_l   (s1_mant_l),
                .i_mant_s   (s1_mant_s),
                .i_sticky   (s1_sticky),
                .o_valid    (s2_valid),
                .o_sign     (s2_sign),
                .o_exp_l    (s2_exp_l),
                .o_sum      (s2_sum),
                .o_sticky   (s2_sticky),
                .o_sum_zero (s2_sum_zero)
        );

        bf16_normalize_round u_norm (
                .i_clk            (i_clk),
                .i_rst_n          (i_rst_n),
                .i_valid          (s2_valid),
                .i_sign           (s2_sign),
                .i_exp_l          (s2_exp_l),
                .i_sum            (s2_sum),
                .i_sticky         (s2_sticky),
                .i_sum_zero       (s2_sum_zero),
                .i_special        (sp_special),
                .i_special_result (sp_result),
                .i_invalid        (sp_invalid),
                .o_valid          (o_valid),
                .o_result         (o_result),
                .o_overflow       (o_overflow),
                .o_underflow      (o_underflow),
                .o_invalid        (o_invalid)
        );

endmodule : bf16_adder

`default_nettype wire

//--- test/bf16_adder_sva.sv
// BF16 adder assertions

`default_nettype none

module bf16_adder_sva (
        input wire logic            i_clk,
        input wire logic            i_rst_n,
        input wire logic            i_valid,
        input wire logic            o_valid,
        input wire bf16_pkg::bf16_t o_result,
        input wire logic            o_overflow,
        input wire logic            o_underflow,
        input wire logic            o_invalid
);
        timeunit 1ns;
        timeprecision 100ps;

        // Each accepted pair gives one output LATENCY edges later
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_valid |-> ##(bf16_pkg::LATENCY) o_valid)
                else $error("o_valid missing after i_valid");
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_valid |-> $past(i_valid, bf16_pkg::LATENCY))
                else $error("o_valid without a matching i_valid");

        // Overflow always saturates to an infinity
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_overflow |-> (o_result[14:0] == {bf16_pkg::EXP_ALL_ONES, 7'h00}))
                else $error("o_overflow with a non-infinite result");

        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !o_valid |-> !(o_overflow || o_underflow || o_invalid))
                else $error("Flag high while o_valid is low");

endmodule : bf16_adder_sva

bind bf16_adder bf16_adder_sva u_sva (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_overflow  (o_overflow),
        .o_underflow (o_underflow),
        .o_invalid   (o_invalid)
);

`default_nettype wire

//--- test/bf16_adder_tb.sv
// BF16 adder testbench

`default_nettype none

module bf16_adder_tb;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int CLK_PERIOD   = 40;
        localparam int RESET_CYCLES = 10;
        localparam int NUM_DIRECTED = 23;
        localparam int NUM_RANDOM   = 64;
        localparam int NUM_TESTS    = 6;
        // Vectors plus a drain of each test with slack
        localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM +
                                         NUM_TESTS * (bf16_pkg::LATENCY + 8) + 20;

        logic            i_clk = 1'b0;
        logic            i_rst_n, i_valid;
        bf16_pkg::bf16_t i_a, i_b, o_result;
        logic            o_overflow, o_underflow, o_invalid, o_valid;

        // Expected {invalid, overflow, underflow, result} and issue stamps
        logic [18:0]     want_q[$];
        int              stamp_q[$];
        int              neg_count = 0;
        int              checks = 0;
        int              value_errors = 0;
        int              timing_errors = 0;
        logic [31:0]     lfsr = 32'h5264;
        bf16_pkg::bf16_t last_result = '0;

        bf16_adder bf16_adder_inst (.*);

        always #(CLK_PERIOD / 2) i_clk = ~i_clk;

        // ======================================================================
        // Reference model
        // ======================================================================
        function automatic logic [18:0] model_add(input logic [15:0] a, input logic [15:0] b);
                logic [15:0] l, s;
                logic        sign;
                int          e, shift, sig_l, sig_s, sum, sticky, mant;
                if ((a[14:7] == 8'hFF && a[6:0] != 0) || (b[14:7] == 8'hFF && b[6:0] != 0))
                        return {3'b000, bf16_pkg::QNAN};
                if (a[14:0] == 15'h7F80 && b[14:0] == 15'h7F80 && a[15] != b[15])
                        return {3'b100, bf16_pkg::QNAN};
                if (a[14:0] == 15'h7F80)
                        return {3'b000, a};
                if (b[14:0] == 15'h7F80)
                        return {3'b000, b};
                // Zero exponent means zero, subnormals included
                if (a[14:7] == 0 && b[14:7] == 0)
                        return {3'b000, a[15] & b[15], 15'h0000};
                if (a[14:7] == 0)
                        return {3'b000, b};
                if (b[14:7] == 0)
                        return {3'b000, a};
                l      = (a[14:0] >= b[14:0]) ? a : b;
                s      = (a[14:0] >= b[14:0]) ? b : a;
                sign   = l[15];
                e      = l[14:7];
                sig_l  = {1'b1, l[6:0], 3'b000};
                sig_s  = {1'b1, s[6:0], 3'b000};
                sticky = 0;
                for (shift = 0; shift < int'(l[14:7]) - int'(s[14:7]) && shift < 11; shift++) begin
                        sticky = sticky | (sig_s & 1);
                        sig_s  = sig_s >> 1;
                end
                sum = (l[15] != s[15]) ? sig_l - sig_s : sig_l + sig_s;
                if (sum == 0 && sticky == 0)
                        return {3'b000, 16'h0000};
                if (sum >= 2048) begin
                        sticky = sticky | (sum & 1);
                        sum    = sum >> 1;
                        e++;
                end
                for (shift = 0; shift < 11 && sum < 1024; shift++) begin
                        sum = sum << 1;
                        e--;
                end
                mant = sum >> 3;
                // Nearest even on guard, round, sticky
                if (((sum >> 2) & 1) && (((sum >> 1) & 1) || (sum & 1) || sticky || (mant & 1)))
                        mant++;
                if (mant == 256) begin
                        mant = 128;
                        e++;
                end
                if (e >= 255)
                        return {3'b010, sign, 8'hFF, 7'h00};
                if (e <= 0)
                        return {3'b001, sign, 15'h0000};
                return {3'b000, sign, 8'(e), 7'(mant)};
        endfunction

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
        endfunction

        task automatic take_bits(input int n, output logic [15:0] v);
                v = '0;
                repeat (n) begin
                        v    = {v[14:0], lfsr[0]};
                        lfsr = lfsr_step(lfsr);
                end
        endtask

        task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
                checks++;
                if (got !== want) begin
                        $display("Error: %s expected %h got %h", name, want, got);
                        value_errors++;
                end
        endtask

        task automatic check_idle();
                check("o_valid", o_valid, 16'h0);
                check("o_result", o_result, 16'h0);
                check("o_overflow", o_overflow, 16'h0);
                check("o_underflow", o_underflow, 16'h0);
                check("o_invalid", o_invalid, 16'h0);
        endtask

        task automatic send(input logic [15:0] a, input logic [15:0] b);
                @(posedge i_clk);
                i_a     <= a;
                i_b     <= b;
                i_valid <= 1'b1;
                want_q.push_back(model_add(a, b));
                stamp_q.push_back(neg_count);
        endtask

        task automatic drain();
                @(posedge i_clk);
                i_valid <= 1'b0;
                for (int i = 0; i < bf16_pkg::LATENCY + 4 && want_q.size() != 0; i++)
                        @(negedge i_clk);
                if (want_q.size() != 0) begin
                        $display("Results still pending after the pipeline drained");
                        timing_errors++;
                        want_q.delete();
                        stamp_q.delete();
                end
        endtask

        // ======================================================================
        // Output monitor
        // ======================================================================
        always @(negedge i_clk) begin
                logic [18:0] want;
                if (o_valid) begin
                        if (want_q.size() == 0) begin
                                $display("o_valid went high with no result pending");
                                timing_errors++;
                        end else begin
                                want = want_q.pop_front();
                                if (neg_count - stamp_q.pop_front() != bf16_pkg::LATENCY) begin
                                        $display("Result arrived in the wrong cycle");
                                        timing_errors++;
                                end
                                check("o_result", o_result, want[15:0]);
                                check("o_underflow", o_underflow, want[16]);
                                check("o_overflow", o_overflow, want[17]);
                                check("o_invalid", o_invalid, want[18]);
                        end
                        last_result = o_result;
                end else if (i_rst_n && (o_result !== last_result ||
                                         {o_overflow, o_underflow, o_invalid} !== 3'b000)) begin
                        $display("Outputs changed while o_valid was low");
                        timing_errors++;
                end
                if (stamp_q.size() != 0 && neg_count - stamp_q[0] > bf16_pkg::LATENCY) begin
                        $display("No result came out for an accepted operand pair");
                        timing_errors++;
                        void'(want_q.pop_front());
                        void'(stamp_q.pop_front());
                end
                neg_count++;
        end

        // ======================================================================
        // Tests
        // ======================================================================
        task automatic reset_test();
                repeat (RESET_CYCLES) begin
                        @(negedge i_clk);
                        check_idle();
                end
                @(posedge i_clk);
                i_rst_n <= 1'b1;
                repeat (3) begin
                        @(negedge i_clk);
                        check_idle();
                end
        endtask

        task automatic add_test();
                send(16'h3F80, 16'h3F80);
                send(16'h3FC0, 16'h3FC0);
                // Rounding carries into the exponent
                send(16'h3FFF, 16'h3C00);
                send(16'h3FFF, 16'h3B80);
                send(16'h3F80, 16'h3B80);
                drain();
        endtask

        task automatic sub_test();
                send(16'h3F80, 16'hBF80);
                send(16'hBFC0, 16'h3FC0);
                // Near-equal operands need a long left shift
                send(16'h3F81, 16'hBF80);
                send(16'h4000, 16'hBFFF);
                send(16'h3F80, 16'hBB00);
                drain();
        endtask

        task automatic special_test();
                send(16'h7FC1, 16'h3F80);
                send(16'h3F80, 16'hFF81);
                send(16'h7F80, 16'hFF80);
                send(16'h7F80, 16'h3F80);
                send(16'h3F80, 16'hFF80);
                send(16'h8000, 16'h8000);
                send(16'h0001, 16'h4040);
                send(16'hC000, 16'h8040);
                drain();
        endtask

        task automatic range_test();
                send(16'h7F7F, 16'h7F7F);
                send(16'hFF7F, 16'hFF00);
                send(16'h0081, 16'h8080);
                send(16'h8081, 16'h0080);
                send(16'h3F80, 16'h4000);
                drain();
        endtask

        task automatic random_test();
                logic [15:0] a, b;
                for (int n = 0; n < NUM_RANDOM; n++) begin
                        take_bits(16, a);
                        take_bits(16, b);
                        // Odd pairs keep the exponents close
                        if (n % 2)
                                b[14:7] = a[14:7] ^ {5'b00000, b[9:7]};
                        send(a, b);
                end
                drain();
        endtask

        initial begin
                i_rst_n = 1'b0;
                i_valid = 1'b0;
                i_a     = '0;
                i_b     = '0;
                reset_test();
                add_test();
                sub_test();
                special_test();
                range_test();
                random_test();
                repeat (2) @(negedge i_clk);
                $display("Summary: %0d compares, %0d value errors, %0d timing errors",
                         checks, value_errors, timing_errors);
                if (value_errors == 0 && timing_errors == 0 && checks > 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
                $display("Checks failed");
                $finish;
        end

endmodule : bf16_adder_tb

`default_nettype wire

//--- sources.f
common/bf16_pkg.sv
bf16_add/bf16_special_path.sv
bf16_add/bf16_operand_align.sv
bf16_add/bf16_mant_addsub.sv
bf16_add/bf16_normalize_round.sv
verilog/bf16_adder.sv
test/bf16_adder_sva.sv
test/bf16_adder_tb.sv
